/* core_config_pkg.sv */
// widths, vector types and AXI channel payload structs
// shared by the core request path and the word memory
`default_nettype none

package core_config_pkg;

    localparam int ADDR_WIDTH = 32;  // byte address
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;  // one strobe per byte lane
    localparam int ID_WIDTH = 2;
    localparam int MEM_WORDS = 256;
    localparam int BYTE_OFFSET_WIDTH = $clog2(STRB_WIDTH);  // byte bits below the word index
    localparam int WORD_IDX_WIDTH = $clog2(MEM_WORDS);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [ID_WIDTH-1:0] axi_id_t;
    typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;  // memory word index

    // core side request, 69 bits
    typedef struct packed {
        logic we;
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
    } mem_req_t;

    typedef struct packed {
        axi_id_t id;
        addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t id;
        addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic last;  // always set, single beat
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        data_t data;
        logic last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t id;
    } axi_b_t;

endpackage

`default_nettype wire

/* axi_read_channel.sv */
// read channel engine
// arvalid set/clear register and read data capture
`timescale 1ns/1ps
`default_nettype none

module axi_read_channel #(
    parameter core_config_pkg::axi_id_t ID = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,     // new read request this cycle
    input  core_config_pkg::addr_t   req_addr,  // already latched by the master
    input  logic                     arready,
    output logic                     arvalid,
    output core_config_pkg::axi_ar_t ar,
    input  core_config_pkg::axi_r_t  r,
    input  logic                     rvalid,
    output core_config_pkg::data_t   rdata
);

    // set wins over clear, a fresh start is never dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if (start) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;  // handshake done
        end
    end

    // payload stays put while arvalid waits for arready
    assign ar.id   = ID;
    assign ar.addr = req_addr;

    // last returned word, held until the next read response
    always_ff @(posedge clk) begin
        if (rvalid) begin
            rdata <= r.data;
        end
    end

endmodule

`default_nettype wire

/* axi_write_channel.sv */
// write channel engine
// separate awvalid and wvalid set/clear registers, single beat data
`timescale 1ns/1ps
`default_nettype none

module axi_write_channel #(
    parameter core_config_pkg::axi_id_t ID = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,      // new write request this cycle
    input  core_config_pkg::addr_t   req_addr,
    input  core_config_pkg::data_t   req_wdata,
    input  core_config_pkg::strb_t   req_wstrb,
    input  logic                     awready,
    input  logic                     wready,
    output logic                     awvalid,
    output logic                     wvalid,
    output core_config_pkg::axi_aw_t aw,
    output core_config_pkg::axi_w_t  w
);

    // address channel
    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
        end else if (start) begin
            awvalid <= 1'b1;
        end else if (awready) begin
            awvalid <= 1'b0;
        end
    end

    // data channel, may finish on a different edge than the address
    always_ff @(posedge clk) begin
        if (rst) begin
            wvalid <= 1'b0;
        end else if (start) begin
            wvalid <= 1'b1;
        end else if (wready) begin
            wvalid <= 1'b0;
        end
    end

    assign aw.id   = ID;
    assign aw.addr = req_addr;

    assign w.data = req_wdata;
    assign w.strb = req_wstrb;  // byte lanes to update
    assign w.last = wvalid;     // every write is one beat

endmodule

`default_nettype wire

/* axi_response_tracker.sv */
// response tracker
// ready_out from matching read/write responses, valid_out and data_out
`timescale 1ns/1ps
`default_nettype none

module axi_response_tracker #(
    parameter core_config_pkg::axi_id_t ID = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_request,
    input  core_config_pkg::axi_r_t r,
    input  logic                    rvalid,
    input  core_config_pkg::axi_b_t b,
    input  logic                    bvalid,
    input  core_config_pkg::data_t  rdata,      // word captured by the read engine
    output logic                    ready_out,
    output logic                    valid_out,
    output core_config_pkg::data_t  data_out
);

    logic resp_match;

    // only responses carrying our own ID finish the request
    assign resp_match = (rvalid && (r.id == ID)) || (bvalid && (b.id == ID));

    // idle after reset; clear wins over set
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_out <= 1'b1;
        end else if (new_request) begin
            ready_out <= 1'b0;
        end else if (resp_match) begin
            ready_out <= 1'b1;
        end
    end

    // one cycle pulse, lines up with the captured word
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= rvalid;
        end
    end

    assign data_out = rdata;

endmodule

`default_nettype wire

/* axi_master.sv */
// single beat AXI master bridge
// request register, read and write engines, response tracker
`timescale 1ns/1ps
`default_nettype none

module axi_master #(
    parameter core_config_pkg::axi_id_t ID = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    // core side
    input  logic                     new_request,
    input  core_config_pkg::mem_req_t req,
    output logic                     ready_out,
    output logic                     valid_out,
    output core_config_pkg::data_t   data_out,
    // read address / data
    output core_config_pkg::axi_ar_t ar,
    output logic                     arvalid,
    input  logic                     arready,
    input  core_config_pkg::axi_r_t  r,
    input  logic                     rvalid,
    output logic                     rready,
    // write address / data / response
    output core_config_pkg::axi_aw_t aw,
    output logic                     awvalid,
    input  logic                     awready,
    output core_config_pkg::axi_w_t  w,
    output logic                     wvalid,
    input  logic                     wready,
    input  core_config_pkg::axi_b_t  b,
    input  logic                     bvalid,
    output logic                     bready
);
    import core_config_pkg::*;

    mem_req_t req_q;   // held for the whole transaction
    logic start_rd;
    logic start_wr;
    data_t rdata;

    always_ff @(posedge clk) begin
        if (new_request) begin
            req_q <= req;
        end
    end

    // steered from the live request so valids rise on the same edge
    assign start_rd = new_request & ~req.we;
    assign start_wr = new_request & req.we;

    // responses are never back-pressured
    assign rready = 1'b1;
    assign bready = 1'b1;

    axi_read_channel #(
        .ID(ID)
    ) i_read_channel (
        .clk,
        .rst,
        .start(start_rd),
        .req_addr(req_q.addr),
        .arready,
        .arvalid,
        .ar,
        .r,
        .rvalid,
        .rdata
    );

    axi_write_channel #(
        .ID(ID)
    ) i_write_channel (
        .clk,
        .rst,
        .start(start_wr),
        .req_addr(req_q.addr),
        .req_wdata(req_q.wdata),
        .req_wstrb(req_q.wstrb),
        .awready,
        .wready,
        .awvalid,
        .wvalid,
        .aw,
        .w
    );

    axi_response_tracker #(
        .ID(ID)
    ) i_response_tracker (
        .clk,
        .rst,
        .new_request,
        .r,
        .rvalid,
        .b,
        .bvalid,
        .rdata,
        .ready_out,
        .valid_out,
        .data_out
    );

endmodule

`default_nettype wire

/* axi_word_ram.sv */
// single beat AXI slave over an on-chip word array
// strobe masked writes, ID echoed on r and b
`timescale 1ns/1ps
`default_nettype none

module axi_word_ram (
    input  logic                     clk,
    input  logic                     rst,
    input  core_config_pkg::axi_ar_t ar,
    input  logic                     arvalid,
    output logic                     arready,
    output core_config_pkg::axi_r_t  r,
    output logic                     rvalid,
    input  logic                     rready,
    input  core_config_pkg::axi_aw_t aw,
    input  logic                     awvalid,
    output logic                     awready,
    input  core_config_pkg::axi_w_t  w,
    input  logic                     wvalid,
    output logic                     wready,
    output core_config_pkg::axi_b_t  b,
    output logic                     bvalid,
    input  logic                     bready
);
    import core_config_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_RESP,
        ST_WRITE_COLLECT,  // one of aw / w still missing
        ST_WRITE_RESP
    } ram_state_e;

    ram_state_e state;
    data_t mem [MEM_WORDS] = '{default: '0};
    axi_ar_t ar_q;
    axi_aw_t aw_q;
    axi_w_t w_q;
    logic aw_got;  // address beat taken
    logic w_got;   // data beat taken
    logic ar_fire;
    logic aw_fire;
    logic w_fire;
    logic wr_ready;  // both halves of the write present
    word_idx_t rd_idx;
    word_idx_t wr_idx;
    data_t wr_word;

    assign arready = (state == ST_IDLE);
    assign awready = ((state == ST_IDLE) || (state == ST_WRITE_COLLECT)) && !aw_got;
    assign wready  = ((state == ST_IDLE) || (state == ST_WRITE_COLLECT)) && !w_got;

    assign ar_fire  = arvalid & arready;
    assign aw_fire  = awvalid & awready;
    assign w_fire   = wvalid & wready;
    assign wr_ready = (aw_got | aw_fire) & (w_got | w_fire);

    // upper address bits dropped, so addresses alias
    assign rd_idx = ar_q.addr[BYTE_OFFSET_WIDTH +: WORD_IDX_WIDTH];
    assign wr_idx = aw_q.addr[BYTE_OFFSET_WIDTH +: WORD_IDX_WIDTH];

    // merge new bytes over the stored word
    always_comb begin
        wr_word = mem[wr_idx];
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (w_q.strb[i]) begin
                wr_word[8*i +: 8] = w_q.data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            if (aw_fire) aw_got <= 1'b1;
            if (w_fire) w_got <= 1'b1;
            unique case (state)
                ST_IDLE: begin
                    // master never raises read and write together
                    if (ar_fire) begin
                        state <= ST_READ_RESP;
                    end else if (wr_ready) begin
                        state <= ST_WRITE_RESP;
                    end else if (aw_fire || w_fire) begin
                        state <= ST_WRITE_COLLECT;
                    end
                end
                ST_WRITE_COLLECT: begin
                    if (wr_ready) state <= ST_WRITE_RESP;
                end
                ST_READ_RESP: begin
                    if (!rvalid) begin
                        rvalid <= 1'b1;  // data loaded below
                    end else if (rready) begin
                        rvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                ST_WRITE_RESP: begin
                    if (!bvalid) begin
                        bvalid <= 1'b1;  // word committed on this edge
                    end else if (bready) begin
                        bvalid <= 1'b0;
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // channel payloads and response contents
    always_ff @(posedge clk) begin
        if (ar_fire) ar_q <= ar;
        if (aw_fire) aw_q <= aw;
        if (w_fire) w_q <= w;
        if (state == ST_READ_RESP && !rvalid) begin
            r.id   <= ar_q.id;
            r.data <= mem[rd_idx];
            r.last <= 1'b1;
        end
        if (state == ST_WRITE_RESP && !bvalid) begin
            b.id <= aw_q.id;
        end
    end

    // memory array, one write per transaction
    always_ff @(posedge clk) begin
        if (state == ST_WRITE_RESP && !bvalid) begin
            mem[wr_idx] <= wr_word;
        end
    end

endmodule

`default_nettype wire

/* cpu_mem_subsystem.sv */
// top level, core request port to the AXI word memory
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_subsystem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      new_request,
    input  core_config_pkg::mem_req_t req,
    output logic                      ready_out,
    output logic                      valid_out,
    output core_config_pkg::data_t    data_out
);
    import core_config_pkg::*;

    axi_ar_t ar;
    axi_aw_t aw;
    axi_w_t w;
    axi_r_t r;
    axi_b_t b;
    logic arvalid;
    logic arready;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic rvalid;
    logic rready;
    logic bvalid;
    logic bready;

    axi_master #(
        .ID(2'd1)  // matched against r.id / b.id
    ) i_axi_master (
        .clk, .rst,
        .new_request, .req,
        .ready_out, .valid_out, .data_out,
        .ar, .arvalid, .arready,
        .r, .rvalid, .rready,
        .aw, .awvalid, .awready,
        .w, .wvalid, .wready,
        .b, .bvalid, .bready
    );

    axi_word_ram i_axi_word_ram (
        .clk, .rst,
        .ar, .arvalid, .arready,
        .r, .rvalid, .rready,
        .aw, .awvalid, .awready,
        .w, .wvalid, .wready,
        .b, .bvalid, .bready
    );

endmodule

`default_nettype wire

/* tb_cpu_mem_subsystem.sv */
// testbench for the CPU memory subsystem
// directed operations from mem_stimulus.txt, LFSR random phase, shadow word model
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_mem_subsystem;
    import core_config_pkg::*;

    localparam int MAX_OPS = 64;       // directed table depth
    localparam int RAND_OPS = 64;
    localparam int RESP_LATENCY = 3;   // new_request edge to ready_out

    logic clk = 1'b0;
    logic rst;
    logic new_request;
    mem_req_t req;
    logic ready_out;
    logic valid_out;
    data_t data_out;

    mem_req_t dir_req [MAX_OPS];
    data_t dir_exp [MAX_OPS];
    int n_dir;
    data_t model_mem [MEM_WORDS];      // shadow of the word array
    logic [15:0] lfsr_q = 16'd26;
    int cycle_count = 0;
    int timeout_limit = 8 * (MAX_OPS + RAND_OPS) + 200;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic loaded;

    cpu_mem_subsystem i_cpu_mem_subsystem (
        .clk, .rst, .new_request, .req, .ready_out, .valid_out, .data_out
    );

    always #5 clk = ~clk;  // 10 ns period

    // run limit for a handshake that never completes
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("simulation timed out after %0d cycles, DUT stopped responding",
                     cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_q[15]};  // one step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic data_t strobe_merge(input data_t old_word, input data_t new_word,
                                           input strb_t strb);
        data_t res;
        res = old_word;
        for (int lane = 0; lane < STRB_WIDTH; lane++) begin
            if (strb[lane]) res[8*lane +: 8] = new_word[8*lane +: 8];
        end
        return res;
    endfunction

    function automatic int word_of(input addr_t a);
        return (a / STRB_WIDTH) % MEM_WORDS;  // upper bits alias
    endfunction

    task automatic check_data(input data_t actual, input data_t expected, input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s, got %b, expected %b", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_count != errs_before) tests_failed++;
        $display("test %0d %s: %s", tests_run, name,
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    // one request and its wait on ready_out, entered at posedge + 1 ns
    task automatic run_op(input mem_req_t op, input data_t expected, input string tag);
        int lat;
        new_request = 1'b1;
        req = op;
        @(posedge clk);
        #1;
        new_request = 1'b0;
        req = '0;
        lat = 0;
        while (ready_out !== 1'b1) begin
            check_flag(valid_out, 1'b0, {tag, ", valid_out while busy"});
            @(posedge clk);
            #1;
            lat++;
        end
        check_flag(lat == RESP_LATENCY, 1'b1,
                   $sformatf("%s, ready_out back after %0d cycles", tag, lat));
        check_flag(valid_out, ~op.we, {tag, ", valid_out with response"});
        if (!op.we) check_data(data_out, expected, {tag, ", read data"});
    endtask

    task automatic load_stimulus(output logic ok);
        int fd;
        int code;
        logic [63:0] tok;
        logic [8*200-1:0] rest;
        mem_req_t rq;
        addr_t f_addr;
        data_t f_wdata;
        strb_t f_strb;
        data_t f_exp;
        ok = 1'b1;
        n_dir = 0;
        fd = $fopen("mem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open mem_stimulus.txt");
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);  // comment line
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", f_addr, f_wdata, f_strb, f_exp);
                    if (code != 4 || (tok != "W" && tok != "R") || n_dir == MAX_OPS) begin
                        $display("unreadable stimulus entry %0d", n_dir + 1);
                        ok = 1'b0;
                    end else begin
                        rq.we = (tok == "W");
                        rq.addr = f_addr;
                        rq.wdata = f_wdata;
                        rq.wstrb = f_strb;
                        dir_req[n_dir] = rq;
                        dir_exp[n_dir] = f_exp;
                        n_dir++;
                    end
                end
            end
            $fclose(fd);
        end
        timeout_limit = 8 * (n_dir + RAND_OPS) + 200;
    endtask

    task automatic run_tests();
        mem_req_t op;
        addr_t a;
        logic [31:0] bits;
        int idx;
        int errs_before;
        string tag;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        errs_before = error_count;
        check_flag(ready_out, 1'b1, "ready_out after reset");
        check_flag(valid_out, 1'b0, "valid_out after reset");
        @(posedge clk);
        #1;
        check_flag(ready_out, 1'b1, "ready_out idle");
        check_flag(valid_out, 1'b0, "valid_out idle");
        finish_test("reset state", errs_before);

        for (int i = 0; i < n_dir; i++) begin
            errs_before = error_count;
            op = dir_req[i];
            idx = word_of(op.addr);
            tag = $sformatf("%s %h", op.we ? "W" : "R", op.addr);
            if (op.we) begin
                run_op(op, '0, tag);
                model_mem[idx] = strobe_merge(model_mem[idx], op.wdata, op.wstrb);
            end else begin
                check_data(model_mem[idx], dir_exp[i], {tag, ", model vs file"});
                run_op(op, dir_exp[i], tag);
            end
            finish_test(tag, errs_before);
        end

        // back to back over 32 words so reads hit earlier writes
        errs_before = error_count;
        for (int i = 0; i < RAND_OPS; i++) begin
            a = '0;
            take_bits(1, bits);
            op.we = bits[0];
            take_bits(2, bits);
            a[11:10] = bits[1:0];  // aliasing bits above the depth
            take_bits(5, bits);
            a[6:2] = bits[4:0];
            take_bits(2, bits);
            a[1:0] = bits[1:0];    // byte offset the memory ignores
            op.addr = a;
            take_bits(32, bits);
            op.wdata = bits;
            take_bits(4, bits);
            op.wstrb = bits[3:0];
            idx = word_of(op.addr);
            tag = $sformatf("random %0d %s %h", i, op.we ? "W" : "R", op.addr);
            run_op(op, model_mem[idx], tag);
            if (op.we) model_mem[idx] = strobe_merge(model_mem[idx], op.wdata, op.wstrb);
        end
        @(posedge clk);
        #1;
        check_flag(valid_out, 1'b0, "valid_out one cycle after last response");
        finish_test("random phase", errs_before);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        rst = 1'b1;
        new_request = 1'b0;
        req = '0;
        for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;  // memory starts zeroed
        load_stimulus(loaded);
        if (!loaded) begin
            $display("stimulus could not be loaded, no test was run");
            $display("*** TEST FAILED ***");
        end else begin
            run_tests();
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     tests_run, tests_run - tests_failed, tests_failed, error_count);
            if (error_count == 0 && tests_failed == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_stimulus.txt */
# op addr wdata strb expected, all hex; W ignores expected
# R compares data_out with expected
R 00000010 00000000 0 00000000
W 00000010 11223344 f 00000000
R 00000010 00000000 0 11223344
R 00000410 00000000 0 11223344
R fffffc12 00000000 0 11223344
W 00000020 aabbccdd f 00000000
W 00000020 00000011 1 00000000
R 00000020 00000000 0 aabbcc11
W 00000020 00002200 2 00000000
W 00000020 00330000 4 00000000
W 00000020 44000000 8 00000000
R 00000020 00000000 0 44332211
W 00000024 deadbeef 5 00000000
R 00000024 00000000 0 00ad00ef
W 00000024 12345678 a 00000000
R 00000024 00000000 0 12ad56ef
W 00000024 ffffffff 0 00000000
R 00000024 00000000 0 12ad56ef
R 00000100 00000000 0 00000000
W 000003fc cafef00d f 00000000
R 000003fc 00000000 0 cafef00d
R 000007fc 00000000 0 cafef00d
R 00000000 00000000 0 00000000
W 00000400 01020304 f 00000000
R 00000000 00000000 0 01020304
W 00000010 00000000 3 00000000
R 00000410 00000000 0 11220000
W 80000020 ffffffff 6 00000000
R 00000020 00000000 0 44ffff11
R 00000024 00000000 0 12ad56ef

/* flist.f */
core_config_pkg.sv
axi_read_channel.sv
axi_write_channel.sv
axi_response_tracker.sv
axi_master.sv
axi_word_ram.sv
cpu_mem_subsystem.sv
tb_cpu_mem_subsystem.sv
